/* include/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ============================================================
// datapath widths
// ============================================================
`define VD_CH_W          8   // one colour channel
`define VD_KEY_W         2
`define VD_BTN_W         6   // button field of the status word
`define VD_IR_CODE_W     16
`define VD_IR_CNT_W      8
`define VD_LED_W         8
`define VD_SYS_CTRL_W    16

// ============================================================
// system control word bit positions
// ============================================================
`define SYS_CTRL_HSYNC_POL  8
`define SYS_CTRL_VSYNC_POL  9
`define SYS_CTRL_FRAMELOCK  14
`define SYS_CTRL_PAIR_SEL   15  // 1 = frame-buffer return path

// osd palette in {r, g, b} order
`define OSD_RGB_BLACK    24'h000000
`define OSD_RGB_BLUE     24'h0000ff
`define OSD_RGB_YELLOW   24'hffff00
`define OSD_RGB_WHITE    24'hffffff

// resync led stretcher width for about 0.6 s at 27 MHz
`define RESYNC_STRETCH_W_DEF  24

// buttons are active low
`define BTN_IDLE         {`VD_BTN_W{1'b1}}

`endif

/* design/video_pkg.sv */
`default_nettype none

`include "video_consts.svh"

package video_pkg;

    // ============================================================
    // pixel words
    // ============================================================
    typedef struct packed {
        logic [`VD_CH_W-1:0] r;
        logic [`VD_CH_W-1:0] g;
        logic [`VD_CH_W-1:0] b;
    } rgb_t;

    // raw digitizer pins with syncs in source polarity
    typedef struct packed {
        rgb_t rgb;
        logic hsync;
        logic vsync;
        logic de;
        logic datavalid;
        logic fid;
    } isl_in_t;

    typedef struct packed {
        rgb_t rgb;
        logic hsync_n;
        logic vsync_n;
        logic de;     // already qualified by datavalid
        logic fid_n;
    } cap_word_t;

    typedef struct packed {
        cap_word_t first;   // earlier pixel in the upper half
        cap_word_t second;
    } cap_pair_t;

    typedef struct packed {
        rgb_t rgb;
        logic hsync_n;
        logic vsync_n;
        logic de;
    } out_word_t;

    typedef struct packed {
        out_word_t first;
        out_word_t second;
    } out_pair_t;

    // hdmi transmitter pins with active high syncs
    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
        logic de;
    } hdmi_tx_t;

    // ============================================================
    // control and status
    // ============================================================
    typedef logic [`VD_SYS_CTRL_W-1:0] sys_ctrl_t;  // fields by bit position

    typedef struct packed {
        logic hsync_pol;
        logic vsync_pol;
    } cap_cfg_t;

    typedef struct packed {
        logic [1:0]              rsvd;
        logic [`VD_BTN_W-1:0]     btn;
        logic [`VD_IR_CNT_W-1:0]  ir_code_cnt;
        logic [`VD_IR_CODE_W-1:0] ir_code;
    } controls_t;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_t;

endpackage

`default_nettype wire

/* design/vd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module vd_ctrl #(
    parameter int RESYNC_STRETCH_W = `RESYNC_STRETCH_W_DEF
) (
    input  wire                          clk27,
    input  wire                          sys_reset_n,
    input  wire video_pkg::sys_ctrl_t    sys_ctrl_i,
    input  wire [`VD_KEY_W-1:0]          key_i,
    input  wire [`VD_IR_CODE_W-1:0]      ir_code_i,
    input  wire [`VD_IR_CNT_W-1:0]       ir_code_cnt_i,
    input  wire                          resync_strobe_i,
    output video_pkg::cap_cfg_t          cap_cfg_o,
    output logic                         pair_path_sel_o,
    output video_pkg::controls_t         controls_o,
    output logic [`VD_LED_W-1:0]         led_o
);

    video_pkg::sys_ctrl_t        sys_ctrl_q;
    logic [`VD_BTN_W-1:0]        btn_sync1_q;
    logic [`VD_BTN_W-1:0]        btn_sync2_q;
    logic [`VD_IR_CODE_W-1:0]    ir_code_q;
    logic [`VD_IR_CNT_W-1:0]     ir_cnt_q;
    logic                        ir_zero_q;
    logic                        resync_sync1_q;
    logic                        resync_sync2_q;
    logic                        resync_prev_q;
    logic [RESYNC_STRETCH_W-1:0] resync_ctr_q;
    logic                        resync_rise;

    // ============================================================
    // control word, ir code and buttons
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            sys_ctrl_q  <= '0;
            ir_code_q   <= '0;
            ir_cnt_q    <= '0;
            ir_zero_q   <= 1'b0;
            btn_sync1_q <= `BTN_IDLE;
            btn_sync2_q <= `BTN_IDLE;
        end else begin
            sys_ctrl_q  <= sys_ctrl_i;
            ir_code_q   <= ir_code_i;
            ir_cnt_q    <= ir_code_cnt_i;
            ir_zero_q   <= (ir_code_i == '0);  // no code received yet
            btn_sync1_q <= {key_i[1], 1'b1, key_i[0], 3'b111};
            btn_sync2_q <= btn_sync1_q;
        end
    end

    assign cap_cfg_o.hsync_pol = sys_ctrl_q[`SYS_CTRL_HSYNC_POL];
    assign cap_cfg_o.vsync_pol = sys_ctrl_q[`SYS_CTRL_VSYNC_POL];
    assign pair_path_sel_o     = sys_ctrl_q[`SYS_CTRL_PAIR_SEL];

    assign controls_o.rsvd        = 2'b00;
    assign controls_o.btn         = btn_sync2_q;
    assign controls_o.ir_code_cnt = ir_cnt_q;
    assign controls_o.ir_code     = ir_code_q;

    // ============================================================
    // resync led stretcher
    // ============================================================
    assign resync_rise = resync_sync2_q & ~resync_prev_q;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_sync1_q <= 1'b0;
            resync_sync2_q <= 1'b0;
            resync_prev_q  <= 1'b0;
            resync_ctr_q   <= '0;
        end else begin
            resync_sync1_q <= resync_strobe_i;
            resync_sync2_q <= resync_sync1_q;
            resync_prev_q  <= resync_sync2_q;
            if (resync_rise) begin
                resync_ctr_q <= '1;  // restart on every new edge
            end else if (resync_ctr_q != '0) begin
                resync_ctr_q <= resync_ctr_q - 1'b1;
            end
        end
    end

    // led 7 ir idle, led 1 resync, led 0 framelock
    assign led_o = {ir_zero_q, 5'b0_0000, (resync_ctr_q != '0),
                    sys_ctrl_q[`SYS_CTRL_FRAMELOCK]};

endmodule

`default_nettype wire

/* design/capture_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// first register after the digitizer pins
//
// syncs leave this stage active low whatever the source polarity,
// and de only counts on cycles the digitizer marks as valid
module capture_stage (
    input  wire                       clk27,
    input  wire                       sys_reset_n,
    input  wire video_pkg::isl_in_t   isl_i,
    input  wire video_pkg::cap_cfg_t  cap_cfg_i,
    output video_pkg::cap_word_t      cap_word_o
);

    logic hsync_n_d;
    logic vsync_n_d;
    logic de_d;

    // ============================================================
    // normalisation
    // ============================================================
    // pol 1 means the source sync is active high
    assign hsync_n_d = isl_i.hsync ^ cap_cfg_i.hsync_pol;
    assign vsync_n_d = isl_i.vsync ^ cap_cfg_i.vsync_pol;
    assign de_d      = isl_i.de & isl_i.datavalid;

    // ============================================================
    // capture register
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            cap_word_o <= '0;
        end else begin
            cap_word_o.rgb     <= isl_i.rgb;
            cap_word_o.hsync_n <= hsync_n_d;
            cap_word_o.vsync_n <= vsync_n_d;
            cap_word_o.de      <= de_d;
            cap_word_o.fid_n   <= ~isl_i.fid;  // field id inverted for the frame buffer
        end
    end

endmodule

`default_nettype wire

/* design/pixel_pair_packer.sv */
`timescale 1ns/1ps
`default_nettype none

// two pixels per word toward the frame-buffer path
module pixel_pair_packer (
    input  wire                        clk27,
    input  wire                        sys_reset_n,
    input  wire video_pkg::cap_word_t  cap_word_i,
    output video_pkg::cap_pair_t       pair_o,
    output logic                       pair_valid_o
);

    logic                 phase_q;  // 0 = collecting first half
    video_pkg::cap_word_t first_q;

    // ============================================================
    // phase and strobe
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            phase_q      <= 1'b0;
            pair_valid_o <= 1'b0;
        end else begin
            phase_q      <= ~phase_q;
            pair_valid_o <= phase_q;  // pair complete after the second half
        end
    end

    // ============================================================
    // pair assembly
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            first_q <= '0;
            pair_o  <= '0;
        end else if (!phase_q) begin
            first_q <= cap_word_i;
        end else begin
            pair_o.first  <= first_q;
            pair_o.second <= cap_word_i;
        end
    end

endmodule

`default_nettype wire

/* design/pixel_pair_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

// splits returned pairs back into one pixel per cycle
module pixel_pair_unpacker (
    input  wire                        clk27,
    input  wire                        sys_reset_n,
    input  wire video_pkg::out_pair_t  pair_i,
    input  wire                        pair_valid_i,
    output video_pkg::out_word_t       ret_word_o,
    output logic                       ret_valid_o
);

    // blanking with syncs inactive
    localparam video_pkg::out_word_t IDLE_WORD = '{
        rgb:     '0,
        hsync_n: 1'b1,
        vsync_n: 1'b1,
        de:      1'b0
    };

    logic                 pend_q;    // second half waiting
    video_pkg::out_word_t second_q;

    // ============================================================
    // output sequencing
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            pend_q      <= 1'b0;
            ret_valid_o <= 1'b0;
            ret_word_o  <= IDLE_WORD;
        end else if (pair_valid_i) begin
            ret_word_o  <= pair_i.first;
            pend_q      <= 1'b1;
            ret_valid_o <= 1'b1;
        end else if (pend_q) begin
            ret_word_o  <= second_q;
            pend_q      <= 1'b0;
            ret_valid_o <= 1'b1;
        end else begin
            ret_word_o  <= IDLE_WORD;
            ret_valid_o <= 1'b0;
        end
    end

    // holding register for the later pixel
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            second_q <= '0;
        end else if (pair_valid_i) begin
            second_q <= pair_i.second;
        end
    end

endmodule

`default_nettype wire

/* design/osd_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module osd_output_stage (
    input  wire                         clk27,
    input  wire                         sys_reset_n,
    input  wire video_pkg::cap_word_t   cap_word_i,
    input  wire video_pkg::out_word_t   ret_word_i,
    input  wire                         pair_path_sel_i,
    input  wire                         osd_enable_i,
    input  wire video_pkg::osd_color_t  osd_color_i,
    output video_pkg::hdmi_tx_t         hdmi_o
);

    video_pkg::out_word_t src_word;
    video_pkg::hdmi_tx_t  stage1_d;
    video_pkg::hdmi_tx_t  stage1_q;

    function automatic video_pkg::rgb_t osd_rgb(input video_pkg::osd_color_t color);
        video_pkg::rgb_t rgb;
        case (color)
            video_pkg::OSD_BLACK:  rgb = `OSD_RGB_BLACK;
            video_pkg::OSD_BLUE:   rgb = `OSD_RGB_BLUE;
            video_pkg::OSD_YELLOW: rgb = `OSD_RGB_YELLOW;
            default:               rgb = `OSD_RGB_WHITE;
        endcase
        return rgb;
    endfunction

    // ============================================================
    // source select and overlay
    // ============================================================
    always_comb begin
        if (pair_path_sel_i) begin
            src_word = ret_word_i;
        end else begin
            src_word.rgb     = cap_word_i.rgb;
            src_word.hsync_n = cap_word_i.hsync_n;
            src_word.vsync_n = cap_word_i.vsync_n;
            src_word.de      = cap_word_i.de;
        end

        stage1_d.rgb = osd_enable_i ? osd_rgb(osd_color_i) : src_word.rgb;
        stage1_d.hs  = ~src_word.hsync_n;  // hdmi side wants active high
        stage1_d.vs  = ~src_word.vsync_n;
        stage1_d.de  = src_word.de;
    end

    // ============================================================
    // two output registers with the second one at the pins
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            stage1_q <= '0;
            hdmi_o   <= '0;
        end else begin
            stage1_q <= stage1_d;
            hdmi_o   <= stage1_q;
        end
    end

endmodule

`default_nettype wire

/* design/vd_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module vd_top #(
    parameter int RESYNC_STRETCH_W = `RESYNC_STRETCH_W_DEF
) (
    input  wire                         clk27,
    input  wire                         sys_reset_n,
    input  wire video_pkg::isl_in_t     isl_i,
    input  wire video_pkg::sys_ctrl_t   sys_ctrl_i,
    input  wire [`VD_KEY_W-1:0]         key_i,
    input  wire [`VD_IR_CODE_W-1:0]     ir_code_i,
    input  wire [`VD_IR_CNT_W-1:0]      ir_code_cnt_i,
    input  wire                         resync_strobe_i,
    input  wire                         osd_enable_i,
    input  wire video_pkg::osd_color_t  osd_color_i,
    input  wire video_pkg::out_pair_t   pair_i,
    input  wire                         pair_valid_i,
    output video_pkg::cap_pair_t        pair_o,
    output logic                        pair_valid_o,
    output video_pkg::hdmi_tx_t         hdmi_o,
    output video_pkg::controls_t        controls_o,
    output logic [`VD_LED_W-1:0]        led_o
);

    video_pkg::cap_cfg_t  cap_cfg;
    video_pkg::cap_word_t cap_word;
    video_pkg::out_word_t ret_word;
    logic                 pair_path_sel;

    // ============================================================
    // control
    // ============================================================
    vd_ctrl #(
        .RESYNC_STRETCH_W (RESYNC_STRETCH_W)
    ) u_ctrl (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .sys_ctrl_i      (sys_ctrl_i),
        .key_i           (key_i),
        .ir_code_i       (ir_code_i),
        .ir_code_cnt_i   (ir_code_cnt_i),
        .resync_strobe_i (resync_strobe_i),
        .cap_cfg_o       (cap_cfg),
        .pair_path_sel_o (pair_path_sel),
        .controls_o      (controls_o),
        .led_o           (led_o)
    );

    // ============================================================
    // capture and frame-buffer pairing
    // ============================================================
    capture_stage u_capture (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .isl_i       (isl_i),
        .cap_cfg_i   (cap_cfg),
        .cap_word_o  (cap_word)
    );

    pixel_pair_packer u_packer (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .cap_word_i   (cap_word),
        .pair_o       (pair_o),
        .pair_valid_o (pair_valid_o)
    );

    pixel_pair_unpacker u_unpacker (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .pair_i       (pair_i),
        .pair_valid_i (pair_valid_i),
        .ret_word_o   (ret_word),
        .ret_valid_o  ()  // idle words already blanked
    );

    // output towards the hdmi transmitter
    osd_output_stage u_output (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .cap_word_i      (cap_word),
        .ret_word_i      (ret_word),
        .pair_path_sel_i (pair_path_sel),
        .osd_enable_i    (osd_enable_i),
        .osd_color_i     (osd_color_i),
        .hdmi_o          (hdmi_o)
    );

endmodule

`default_nettype wire

/* verif/tb_vd_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module tb_vd_top;

    localparam int STRETCH_W = 4;
    localparam int N_STREAM  = 12;
    localparam int N_PAIR    = 8;
    localparam int N_STATUS  = 6;
    localparam logic [N_PAIR-1:0] PAIR_SENT = 8'b1011_0111;  // entry j sent when bit j set

    // sync bits from high to low are hsync vsync de datavalid fid hsync_pol vsync_pol
    typedef struct packed {
        logic [6:0]            sync;
        logic                  osd_on;
        video_pkg::osd_color_t color;
        logic [23:0]           osd_rgb;  // colour expected on hdmi
    } stream_row_t;

    typedef struct packed {
        logic [1:0]  key;
        logic [15:0] ir_code;
        logic [7:0]  ir_cnt;
        logic        framelock;
    } status_row_t;

    stream_row_t stream_tab [N_STREAM] = '{
        '{7'b0_0_1_1_0_1_1, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b1_0_1_1_1_1_1, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b0_1_1_1_0_1_1, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b1_1_1_0_1_0_0, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b0_0_0_1_0_0_0, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b1_0_1_1_0_1_0, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b0_1_1_1_1_0_1, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b0_0_1_0_0_1_1, 1'b0, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b1_0_1_1_0_1_1, 1'b1, video_pkg::OSD_BLUE,   `OSD_RGB_BLUE},
        '{7'b0_1_1_1_1_1_1, 1'b1, video_pkg::OSD_WHITE,  `OSD_RGB_WHITE},
        '{7'b1_1_1_1_0_0_0, 1'b1, video_pkg::OSD_BLACK,  `OSD_RGB_BLACK},
        '{7'b0_0_1_1_1_0_1, 1'b1, video_pkg::OSD_YELLOW, `OSD_RGB_YELLOW}
    };

    status_row_t status_tab [N_STATUS] = '{
        '{2'b11, 16'h0000, 8'h00, 1'b0},
        '{2'b10, 16'h1f2e, 8'h01, 1'b1},
        '{2'b01, 16'h0000, 8'h02, 1'b1},
        '{2'b00, 16'hc35a, 8'h7f, 1'b0},
        '{2'b10, 16'hffff, 8'hff, 1'b1},
        '{2'b11, 16'h0001, 8'h80, 1'b0}
    };

    logic                  clk27 = 1'b0;
    logic                  sys_reset_n;
    video_pkg::isl_in_t    isl;
    video_pkg::sys_ctrl_t  sys_ctrl;
    logic [1:0]            key;
    logic [15:0]           ir_code;
    logic [7:0]            ir_cnt;
    logic                  resync_strobe;
    logic                  osd_enable;
    video_pkg::osd_color_t osd_color;
    video_pkg::out_pair_t  pair_in;
    logic                  pair_valid_in;
    video_pkg::cap_pair_t  pair_out;
    logic                  pair_valid_out;
    video_pkg::hdmi_tx_t   hdmi;
    video_pkg::controls_t  controls;
    logic [7:0]            led;

    video_pkg::rgb_t       pix_rgb [N_STREAM];
    video_pkg::out_pair_t  pair_tab [N_PAIR];
    int                    seed;
    int                    errors = 0;
    int                    checks = 0;

    always #4 clk27 = ~clk27;  // 8 ns period

    vd_top #(
        .RESYNC_STRETCH_W (STRETCH_W)
    ) DUT (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .isl_i           (isl),
        .sys_ctrl_i      (sys_ctrl),
        .key_i           (key),
        .ir_code_i       (ir_code),
        .ir_code_cnt_i   (ir_cnt),
        .resync_strobe_i (resync_strobe),
        .osd_enable_i    (osd_enable),
        .osd_color_i     (osd_color),
        .pair_i          (pair_in),
        .pair_valid_i    (pair_valid_in),
        .pair_o          (pair_out),
        .pair_valid_o    (pair_valid_out),
        .hdmi_o          (hdmi),
        .controls_o      (controls),
        .led_o           (led)
    );

    // ============================================================
    // reference model
    // ============================================================
    function automatic video_pkg::cap_word_t cap_model(input int row);
        video_pkg::cap_word_t w;
        logic [6:0]           s;
        s         = stream_tab[row].sync;
        w.rgb     = pix_rgb[row];
        w.hsync_n = s[1] ? ~s[6] : s[6];  // pol 1 means source active high
        w.vsync_n = s[0] ? ~s[5] : s[5];
        w.de      = s[4] & s[3];
        w.fid_n   = ~s[2];
        return w;
    endfunction

    // pins from row p and overlay from row o
    function automatic video_pkg::hdmi_tx_t direct_model(input int p, input int o);
        video_pkg::cap_word_t w;
        video_pkg::hdmi_tx_t  h;
        w     = cap_model(p);
        h.rgb = stream_tab[o].osd_on ? stream_tab[o].osd_rgb : w.rgb;
        h.hs  = ~w.hsync_n;
        h.vs  = ~w.vsync_n;
        h.de  = w.de;
        return h;
    endfunction

    function automatic video_pkg::hdmi_tx_t ret_to_hdmi(input video_pkg::out_word_t w);
        video_pkg::hdmi_tx_t h;
        h.rgb = w.rgb;
        h.hs  = ~w.hsync_n;
        h.vs  = ~w.vsync_n;
        h.de  = w.de;
        return h;
    endfunction

    // pairs go out on even steps only
    function automatic logic pair_sent(input int s);
        if (s < 0 || s % 2 != 0 || s / 2 >= N_PAIR) begin
            return 1'b0;
        end
        return PAIR_SENT[s / 2];
    endfunction

    // ============================================================
    // drivers
    // ============================================================
    task automatic next_cycle;
        @(negedge clk27);
    endtask

    task automatic drive_stream_row(input int row);
        isl.rgb       = pix_rgb[row];
        isl.hsync     = stream_tab[row].sync[6];
        isl.vsync     = stream_tab[row].sync[5];
        isl.de        = stream_tab[row].sync[4];
        isl.datavalid = stream_tab[row].sync[3];
        isl.fid       = stream_tab[row].sync[2];
        osd_enable    = stream_tab[row].osd_on;
        osd_color     = stream_tab[row].color;
    endtask

    // polarity for a row goes out one cycle ahead of its pins
    task automatic set_pol(input int row);
        sys_ctrl                      = '0;
        sys_ctrl[`SYS_CTRL_HSYNC_POL] = stream_tab[row].sync[1];
        sys_ctrl[`SYS_CTRL_VSYNC_POL] = stream_tab[row].sync[0];
    endtask

    // ============================================================
    // direct path, osd overlay and pair output
    // ============================================================
    task automatic stream_pixels;
        video_pkg::hdmi_tx_t  exp_h;
        video_pkg::cap_pair_t exp_p;
        int                   last_pulse;
        int                   pulses;
        last_pulse = -1;
        pulses     = 0;
        set_pol(0);
        next_cycle();
        for (int i = 0; i < N_STREAM + 3; i++) begin
            if (i >= 3) begin
                exp_h = direct_model(i - 3, (i - 2 < N_STREAM) ? i - 2 : N_STREAM - 1);
                checks++;
                if (hdmi !== exp_h) begin
                    $display("** Error: hdmi_o step %0d got %h expected %h", i, hdmi, exp_h);
                    errors++;
                end
            end
            if (pair_valid_out) begin
                pulses++;
                if (last_pulse >= 0 && i - last_pulse != 2) begin
                    $display("pair_valid_o pulses at steps %0d and %0d are not two cycles apart",
                             last_pulse, i);
                    errors++;
                end
                last_pulse = i;
                if (i >= 3 && i - 2 < N_STREAM) begin
                    exp_p.first  = cap_model(i - 3);  // earlier pixel
                    exp_p.second = cap_model(i - 2);
                    checks++;
                    if (pair_out !== exp_p) begin
                        $display("** Error: pair_o step %0d got %h expected %h",
                                 i, pair_out, exp_p);
                        errors++;
                    end
                end
            end
            if (i < N_STREAM) begin
                drive_stream_row(i);
            end
            if (i + 1 < N_STREAM) begin
                set_pol(i + 1);
            end
            next_cycle();
        end
        if (pulses < N_STREAM / 2) begin
            $display("only %0d pair_valid_o pulses seen during the pixel stream", pulses);
            errors++;
        end
    endtask

    // ============================================================
    // frame-buffer return path
    // ============================================================
    task automatic send_return_pairs;
        video_pkg::hdmi_tx_t exp_h;
        logic                idle;
        sys_ctrl                    = '0;
        sys_ctrl[`SYS_CTRL_PAIR_SEL] = 1'b1;
        osd_enable                  = 1'b0;
        repeat (3) next_cycle();
        for (int s = 0; s < 2 * N_PAIR + 4; s++) begin
            idle  = 1'b0;
            exp_h = '0;
            if (s >= 3 && pair_sent(s - 3)) begin
                exp_h = ret_to_hdmi(pair_tab[(s - 3) / 2].first);
            end else if (s >= 4 && pair_sent(s - 4)) begin
                exp_h = ret_to_hdmi(pair_tab[(s - 4) / 2].second);
            end else begin
                idle = 1'b1;  // blanking where only the syncs and de matter
            end
            checks++;
            if (idle ? ({hdmi.hs, hdmi.vs, hdmi.de} !== 3'b000) : (hdmi !== exp_h)) begin
                $display("** Error: hdmi_o return step %0d got %h expected %h", s, hdmi, exp_h);
                errors++;
            end
            pair_valid_in = pair_sent(s);
            if (pair_sent(s)) begin
                pair_in = pair_tab[s / 2];
            end
            next_cycle();
        end
    endtask

    // ============================================================
    // status word and leds
    // ============================================================
    task automatic apply_status_rows;
        video_pkg::controls_t exp_c;
        logic [7:0]           exp_led;
        status_row_t          k_row;
        status_row_t          i_row;
        status_row_t          d_row;
        for (int s = 0; s < N_STATUS + 2; s++) begin
            if (s >= 1) begin
                i_row   = status_tab[(s - 1 < N_STATUS) ? s - 1 : N_STATUS - 1];
                exp_led = {i_row.ir_code == 16'h0000, 6'b00_0000, i_row.framelock};
                checks++;
                if (led !== exp_led) begin
                    $display("** Error: led_o step %0d got %h expected %h", s, led, exp_led);
                    errors++;
                end
            end
            if (s >= 2) begin
                k_row = status_tab[s - 2];  // keys see two sync flops
                exp_c = {2'b00, k_row.key[1], 1'b1, k_row.key[0], 3'b111,
                         i_row.ir_cnt, i_row.ir_code};
                checks++;
                if (controls !== exp_c) begin
                    $display("** Error: controls_o step %0d got %h expected %h",
                             s, controls, exp_c);
                    errors++;
                end
            end
            d_row                         = status_tab[(s < N_STATUS) ? s : N_STATUS - 1];
            key                           = d_row.key;
            ir_code                       = d_row.ir_code;
            ir_cnt                        = d_row.ir_cnt;
            sys_ctrl                      = '0;
            sys_ctrl[`SYS_CTRL_FRAMELOCK] = d_row.framelock;
            next_cycle();
        end
    endtask

    // ============================================================
    // resync led stretcher
    // ============================================================
    // retrig 0 means a single edge, otherwise a second edge at that high sample
    task automatic stretch_resync_led(input int retrig);
        int rise_dly;
        int high_len;
        int exp_len;
        exp_len = (2 ** STRETCH_W) - 1;
        if (retrig > 0) begin
            exp_len = retrig + 2 + exp_len;  // reload shows three samples after the new edge
        end
        resync_strobe = 1'b1;
        next_cycle();
        resync_strobe = 1'b0;
        rise_dly      = 1;
        while (!led[1] && rise_dly < 10) begin
            next_cycle();
            rise_dly++;
        end
        checks++;
        if (!led[1]) begin
            $display("led_o[1] did not rise within 10 cycles of the resync strobe");
            errors++;
        end else if (rise_dly != 3) begin
            $display("** Error: led_o[1] rise delay got %h expected %h", rise_dly, 3);
            errors++;
        end
        high_len = 0;
        while (led[1] && high_len < 40) begin
            high_len++;
            resync_strobe = (high_len == retrig);
            next_cycle();
        end
        resync_strobe = 1'b0;
        checks++;
        if (led[1]) begin
            $display("led_o[1] still high after 40 cycles of stretching");
            errors++;
        end else if (high_len != exp_len) begin
            $display("** Error: led_o[1] high cycles got %h expected %h", high_len, exp_len);
            errors++;
        end
        repeat (4) next_cycle();  // flush the strobe synchroniser
    endtask

    initial begin
        logic [31:0] rnd;
        logic [63:0] wide;
        seed          = 32'h8ce5e02b;
        sys_reset_n   = 1'b0;
        isl           = '0;
        sys_ctrl      = '0;
        key           = 2'b11;
        ir_code       = '0;
        ir_cnt        = '0;
        resync_strobe = 1'b0;
        osd_enable    = 1'b0;
        osd_color     = video_pkg::OSD_BLACK;
        pair_in       = '0;
        pair_valid_in = 1'b0;
        for (int j = 0; j < N_STREAM; j++) begin
            rnd        = $random(seed);
            pix_rgb[j] = rnd[23:0];
        end
        for (int j = 0; j < N_PAIR; j++) begin
            wide        = {$random(seed), $random(seed)};
            pair_tab[j] = wide[53:0];
        end
        repeat (8) next_cycle();
        sys_reset_n = 1'b1;
        next_cycle();

        stream_pixels();
        send_return_pairs();
        apply_status_rows();
        stretch_resync_led(0);
        stretch_resync_led(5);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
design/video_pkg.sv
design/vd_ctrl.sv
design/capture_stage.sv
design/pixel_pair_packer.sv
design/pixel_pair_unpacker.sv
design/osd_output_stage.sv
design/vd_top.sv
verif/tb_vd_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vd_top testbench with verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module tb_vd_top -f compile.f --Mdir "$BUILD_DIR"
"./$BUILD_DIR/Vtb_vd_top" | tee "$LOG"

if grep -q "^Simulation PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
